// File: compile.f
+incdir+hw
hw/rv_core_pkg.sv
hw/axi_rd_pkg.sv
hw/pc_gen.sv
hw/axi_rd_master.sv
hw/inst_mem_slave.sv
hw/if_stage.sv
sim/if_stage_props.sv
sim/tb_if_stage.sv

// File: Bender.yml
package:
  name: if_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_core_pkg.sv
      - hw/axi_rd_pkg.sv
      - hw/pc_gen.sv
      - hw/axi_rd_master.sv
      - hw/inst_mem_slave.sv
      - hw/if_stage.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/if_stage_props.sv
      - sim/tb_if_stage.sv

// File: sim/tb_if_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "fetch_consts.svh"

module tb_if_stage;

  // about 90 fetches of IMEM_LATENCY+4 cycles, 64 load cycles and the stall windows
  // all well under this bound
  localparam int CYCLE_LIMIT = 4000;
  localparam int IDX_W       = $clog2(`IMEM_DEPTH);

  logic                  clk;
  logic                  rst_n;
  logic                  redirect;
  rv_core_pkg::pc_t      redirect_pc;
  logic                  stall;
  logic                  load_en;
  logic [IDX_W-1:0]      load_addr;
  axi_rd_pkg::axi_data_t load_data;
  rv_core_pkg::inst_t    inst;
  rv_core_pkg::pc_t      pc;
  logic                  inst_valid;
  logic                  fetch_err;

  // copy of the loaded program for the model
  axi_rd_pkg::axi_data_t image [`IMEM_DEPTH];
  // next pc the model expects on inst_valid
  rv_core_pkg::pc_t      model_pc;
  logic [31:0]           rng;
  string                 cur_test;
  int                    cycles       = 0;
  int                    checks       = 0;
  int                    errors       = 0;
  int                    err_base     = 0;
  int                    tests_run    = 0;
  int                    tests_failed = 0;
  int                    stall_hits   = 0;

  if_stage DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .stall_i       (stall),
    .load_en_i     (load_en),
    .load_addr_i   (load_addr),
    .load_data_i   (load_data),
    .inst_o        (inst),
    .pc_o          (pc),
    .inst_valid_o  (inst_valid),
    .fetch_err_o   (fetch_err)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // {error flag, instruction} for a fetch at pc
  function automatic logic [32:0] exp_inst(input rv_core_pkg::pc_t fpc);
    rv_core_pkg::pc_t      offset;
    axi_rd_pkg::axi_data_t word;
    offset = fpc - `RESET_PC;
    if (fpc < `RESET_PC || offset >= 64'(8 * `IMEM_DEPTH)) begin
      return {1'b1, `INST_NOP};
    end
    word = image[offset >> 3];
    return {1'b0, fpc[2] ? word[63:32] : word[31:0]};
  endfunction

  // word aligned address inside the memory window
  function automatic rv_core_pkg::pc_t rand_target(input logic [31:0] r);
    return `RESET_PC + 64'(r % (2 * `IMEM_DEPTH)) * 64'd4;
  endfunction

  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  // returns on the negedge where inst_valid is seen
  task automatic wait_delivery();
    do begin
      @(negedge clk);
    end while (!inst_valid);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_base = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == err_base) begin
      $display("test %-20s ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %-20s failed with %0d errors", cur_test, errors - err_base);
    end
  endtask

  // called right after a delivery
  // stall, let the fetch already launched finish, redirect in IDLE, release
  task automatic redirect_idle(input rv_core_pkg::pc_t target);
    @(posedge clk);
    stall <= 1'b1;
    wait_delivery();
    @(posedge clk);
    redirect    <= 1'b1;
    redirect_pc <= target;
    model_pc = target;
    @(posedge clk);
    redirect <= 1'b0;
    stall    <= 1'b0;
  endtask

  // called right after a delivery, lands while the next fetch is in WAIT
  task automatic redirect_in_flight(input rv_core_pkg::pc_t target);
    @(posedge clk);
    redirect    <= 1'b1;
    redirect_pc <= target;
    model_pc = target;
    @(posedge clk);
    redirect <= 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
        $display("timeout after %0d cycles while waiting for a fetch in %s", cycles, cur_test);
        $display("Simulation FAILED");
        $finish;
      end
    end
  end

  // compare every delivery with the model
  always @(negedge clk) begin
    logic [32:0] exp;
    if (rst_n && inst_valid) begin
      exp = exp_inst(model_pc);
      check_val("pc_o", model_pc, pc);
      check_val("inst_o", 64'(exp[31:0]), 64'(inst));
      check_val("fetch_err_o", 64'(exp[32]), 64'(fetch_err));
      model_pc = model_pc + 64'd4;
      if (stall) begin
        stall_hits++;
      end
    end
  end

  initial begin
    int len;
    int assert_fails;
    rst_n       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    stall       = 1'b1;
    load_en     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    model_pc    = `RESET_PC;
    cur_test    = "reset";
    rng         = 32'hfdba7f3e;
    for (int i = 0; i < `IMEM_DEPTH; i++) begin
      rng = xorshift32(rng);
      image[i][31:0] = rng;
      rng = xorshift32(rng);
      image[i][63:32] = rng;
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    start_test("after_reset");
    @(negedge clk);
    check_val("inst_valid_o", 64'd0, 64'(inst_valid));
    check_val("fetch_err_o", 64'd0, 64'(fetch_err));
    check_val("inst_o", 64'(`INST_NOP), 64'(inst));
    check_val("pc_o", `RESET_PC, pc);
    // program goes in while the stall keeps the pc unit idle
    for (int i = 0; i < `IMEM_DEPTH; i++) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= IDX_W'(i);
      load_data <= image[i];
    end
    @(posedge clk);
    load_en <= 1'b0;
    stall   <= 1'b0;
    wait_delivery();
    end_test();

    start_test("sequential_fetch");
    repeat (32) wait_delivery();
    end_test();

    start_test("redirect_idle");
    repeat (6) begin
      rng = xorshift32(rng);
      redirect_idle(rand_target(rng));
      wait_delivery();
      wait_delivery();
    end
    end_test();

    start_test("redirect_in_flight");
    repeat (6) begin
      rng = xorshift32(rng);
      redirect_in_flight(rand_target(rng));
      wait_delivery();
      wait_delivery();
    end
    end_test();

    start_test("stall_windows");
    repeat (6) begin
      rng = xorshift32(rng);
      repeat (rng % 5) @(negedge clk);
      rng = xorshift32(rng);
      len = 1 + int'(rng % 12);
      @(posedge clk);
      stall <= 1'b1;
      stall_hits = 0;
      repeat (len) @(posedge clk);
      stall <= 1'b0;
      if (stall_hits > 1) begin
        errors++;
        $display("%s delivered %0d instructions during one stall window", cur_test,
                 stall_hits);
      end
      wait_delivery();
      wait_delivery();
    end
    end_test();

    start_test("out_of_range");
    // above the window, then below it
    redirect_in_flight(`RESET_PC + 64'(8 * `IMEM_DEPTH) + 64'h40);
    wait_delivery();
    check_val("fetch_err_o", 64'd1, 64'(fetch_err));
    check_val("inst_o", 64'(`INST_NOP), 64'(inst));
    redirect_in_flight(64'h0000_0000_0000_1000);
    wait_delivery();
    check_val("fetch_err_o", 64'd1, 64'(fetch_err));
    check_val("inst_o", 64'(`INST_NOP), 64'(inst));
    end_test();

    // bound assertion instances keep their own failure counts
    assert_fails = DUT.u_out_props.fail_count + DUT.u_axi_rd_master.u_axi_props.fail_count;
    if (assert_fails != 0) begin
      errors += assert_fails;
      $display("bound assertions failed %0d times", assert_fails);
    end

    $display("tests %0d failed %0d checks %0d errors %0d", tests_run, tests_failed, checks,
             errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/if_stage_props.sv
`timescale 1ns/10ps
`default_nettype none
`include "fetch_consts.svh"

module if_stage_props (
  input wire                        clk,
  input wire                        rst_n,
  input wire                        ar_valid_i,
  input wire                        ar_ready_i,
  input wire axi_rd_pkg::axi_addr_t ar_addr_i,
  input wire                        r_valid_i,
  input wire                        r_last_i,
  input wire rv_core_pkg::inst_t    inst_i,
  input wire                        inst_valid_i
);

  // running count of failed assertions
  int fail_count = 0;

  // AR held with the same address until accepted
  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
    else begin
      fail_count++;
      $error("ar_valid dropped or ar_addr moved before ar_ready");
    end

  // one beat per read, so every beat is the last
  r_last_set: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid_i |-> r_last_i)
    else begin
      fail_count++;
      $error("r_valid seen without r_last");
    end

  // bubble cycles show a nop
  nop_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !inst_valid_i |-> inst_i == `INST_NOP)
    else begin
      fail_count++;
      $error("inst_o is not a nop while inst_valid_o is low");
    end

  // a fetch takes several cycles so valid never repeats back to back
  valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_i |=> !inst_valid_i)
    else begin
      fail_count++;
      $error("inst_valid_o high on two cycles in a row");
    end

endmodule

// AXI rules on the master ports
bind axi_rd_master if_stage_props u_axi_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .ar_valid_i   (ar_valid_o),
  .ar_ready_i   (ar_ready_i),
  .ar_addr_i    (ar_addr_o),
  .r_valid_i    (r_valid_i),
  .r_last_i     (r_last_i),
  .inst_i       (`INST_NOP),
  .inst_valid_i (1'b0)
);

// output rules on the stage top
bind if_stage if_stage_props u_out_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .ar_valid_i   (1'b0),
  .ar_ready_i   (1'b1),
  .ar_addr_i    (64'd0),
  .r_valid_i    (1'b0),
  .r_last_i     (1'b1),
  .inst_i       (inst_o),
  .inst_valid_i (inst_valid_o)
);

`default_nettype wire

// File: hw/if_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "fetch_consts.svh"

module if_stage (
  input  wire                              clk,
  input  wire                              rst_n,
  // from decode
  input  wire                              redirect_i,
  input  wire rv_core_pkg::pc_t            redirect_pc_i,
  // mul/div hold
  input  wire                              stall_i,
  // program load
  input  wire                              load_en_i,
  input  wire [$clog2(`IMEM_DEPTH)-1:0]    load_addr_i,
  input  wire axi_rd_pkg::axi_data_t       load_data_i,
  // to decode
  output rv_core_pkg::inst_t               inst_o,
  output rv_core_pkg::pc_t                 pc_o,
  output logic                             inst_valid_o,
  output logic                             fetch_err_o
);

  // pc unit <-> read master
  logic                  fetch_req;
  rv_core_pkg::pc_t      fetch_addr;
  logic                  fetch_done;
  axi_rd_pkg::axi_data_t fetch_data;
  axi_rd_pkg::axi_resp_t fetch_resp;
  logic                  deliver;

  // AXI read channels
  logic                  ar_ready;
  logic                  ar_valid;
  axi_rd_pkg::axi_addr_t ar_addr;
  logic                  r_valid;
  logic                  r_ready;
  axi_rd_pkg::axi_resp_t r_resp;
  axi_rd_pkg::axi_data_t r_data;
  logic                  r_last;

  rv_core_pkg::inst_t    word_sel;
  logic                  is_err;

  pc_gen u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .fetch_done_i  (fetch_done),
    .fetch_req_o   (fetch_req),
    .fetch_addr_o  (fetch_addr),
    .deliver_o     (deliver)
  );

  axi_rd_master u_axi_rd_master (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_req_i  (fetch_req),
    .fetch_addr_i (fetch_addr),
    .fetch_done_o (fetch_done),
    .fetch_data_o (fetch_data),
    .fetch_resp_o (fetch_resp),
    .ar_ready_i   (ar_ready),
    .ar_valid_o   (ar_valid),
    .ar_addr_o    (ar_addr),
    .r_valid_i    (r_valid),
    .r_ready_o    (r_ready),
    .r_resp_i     (r_resp),
    .r_data_i     (r_data),
    .r_last_i     (r_last)
  );

  inst_mem_slave u_inst_mem_slave (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_en_i   (load_en_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i),
    .ar_valid_i  (ar_valid),
    .ar_ready_o  (ar_ready),
    .ar_addr_i   (ar_addr),
    .r_ready_i   (r_ready),
    .r_valid_o   (r_valid),
    .r_resp_o    (r_resp),
    .r_data_o    (r_data),
    .r_last_o    (r_last)
  );

  // pc bit 2 picks the upper half of the 64-bit beat
  assign word_sel = fetch_addr[2] ? fetch_data[63:32] : fetch_data[31:0];
  assign is_err   = (fetch_resp == axi_rd_pkg::DECERR);

  // fetch_addr is still the fetched pc on the deliver cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inst_o       <= `INST_NOP;
      pc_o         <= `RESET_PC;
      inst_valid_o <= 1'b0;
      fetch_err_o  <= 1'b0;
    end else begin
      inst_valid_o <= deliver;
      fetch_err_o  <= deliver && is_err;
      if (deliver) begin
        pc_o <= fetch_addr;
      end
      // bubble or bus error both show a nop
      if (deliver && !is_err) begin
        inst_o <= word_sel;
      end else begin
        inst_o <= `INST_NOP;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/inst_mem_slave.sv
`timescale 1ns/10ps
`default_nettype none
`include "fetch_consts.svh"

module inst_mem_slave (
  input  wire                              clk,
  input  wire                              rst_n,
  // program load, word indexed
  input  wire                              load_en_i,
  input  wire [$clog2(`IMEM_DEPTH)-1:0]    load_addr_i,
  input  wire axi_rd_pkg::axi_data_t       load_data_i,
  // AR channel
  input  wire                              ar_valid_i,
  output logic                             ar_ready_o,
  input  wire axi_rd_pkg::axi_addr_t       ar_addr_i,
  // R channel
  input  wire                              r_ready_i,
  output logic                             r_valid_o,
  output axi_rd_pkg::axi_resp_t            r_resp_o,
  output axi_rd_pkg::axi_data_t            r_data_o,
  output logic                             r_last_o
);

  localparam int IDX_W = $clog2(`IMEM_DEPTH);
  localparam int CNT_W = $clog2(`IMEM_LATENCY + 1);

  axi_rd_pkg::axi_data_t mem [`IMEM_DEPTH];

  logic                  busy_q;
  logic [CNT_W-1:0]      cnt_q;
  axi_rd_pkg::axi_addr_t offset;
  logic                  in_range;
  logic [IDX_W-1:0]      rd_idx;
  logic                  ar_hs;

  // byte offset into the memory window
  assign offset   = ar_addr_i - `RESET_PC;
  assign in_range = (ar_addr_i >= `RESET_PC) && (offset < 64'(8 * `IMEM_DEPTH));
  // word index from bit 3 up, bit 2 picks the half later
  assign rd_idx   = offset[3 +: IDX_W];

  // one outstanding read at a time
  assign ar_ready_o = ~busy_q;
  assign r_last_o   = 1'b1;
  assign ar_hs      = ar_valid_i & ar_ready_o;

  always_ff @(posedge clk) begin
    if (load_en_i) begin
      mem[load_addr_i] <= load_data_i;
    end
  end

  // latency counter, r_valid lands IMEM_LATENCY cycles after AR
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      cnt_q     <= '0;
      r_valid_o <= 1'b0;
    end else begin
      if (ar_hs) begin
        busy_q    <= 1'b1;
        cnt_q     <= CNT_W'(`IMEM_LATENCY - 1);
        // latency of one goes valid straight away
        r_valid_o <= (`IMEM_LATENCY == 1);
      end else if (busy_q && !r_valid_o) begin
        if (cnt_q == CNT_W'(1)) begin
          r_valid_o <= 1'b1;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end else if (r_valid_o && r_ready_i) begin
        // beat taken, free for the next AR
        r_valid_o <= 1'b0;
        busy_q    <= 1'b0;
      end
    end
  end

  // response looked up at AR time, held until the beat is taken
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      r_data_o <= in_range ? mem[rd_idx] : '0;
      r_resp_o <= in_range ? axi_rd_pkg::OKAY : axi_rd_pkg::DECERR;
    end
  end

endmodule

`default_nettype wire

// File: hw/axi_rd_master.sv
`timescale 1ns/10ps
`default_nettype none

module axi_rd_master (
  input  wire                          clk,
  input  wire                          rst_n,
  // fetch side
  input  wire                          fetch_req_i,
  input  wire rv_core_pkg::pc_t        fetch_addr_i,
  output logic                         fetch_done_o,
  output axi_rd_pkg::axi_data_t        fetch_data_o,
  output axi_rd_pkg::axi_resp_t        fetch_resp_o,
  // AR channel
  input  wire                          ar_ready_i,
  output logic                         ar_valid_o,
  output axi_rd_pkg::axi_addr_t        ar_addr_o,
  // R channel
  input  wire                          r_valid_i,
  output logic                         r_ready_o,
  input  wire axi_rd_pkg::axi_resp_t   r_resp_i,
  input  wire axi_rd_pkg::axi_data_t   r_data_i,
  // single beat only, last is not needed here
  input  wire                          r_last_i
);

  axi_rd_pkg::rd_state_e state_q;

  logic ar_hs;
  logic r_hs;

  // valid and ready come straight from the state register
  assign ar_valid_o = (state_q == axi_rd_pkg::ADDR);
  assign r_ready_o  = (state_q == axi_rd_pkg::DATA);

  assign ar_hs = ar_valid_o & ar_ready_i;
  assign r_hs  = r_valid_i & r_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= axi_rd_pkg::IDLE;
      fetch_done_o <= 1'b0;
    end else begin
      // done is a single-cycle pulse
      fetch_done_o <= 1'b0;
      case (state_q)
        axi_rd_pkg::IDLE: begin
          // request is a level, only looked at here
          if (fetch_req_i) begin
            state_q <= axi_rd_pkg::ADDR;
          end
        end
        axi_rd_pkg::ADDR: begin
          if (ar_hs) begin
            state_q <= axi_rd_pkg::DATA;
          end
        end
        axi_rd_pkg::DATA: begin
          if (r_hs) begin
            state_q      <= axi_rd_pkg::IDLE;
            fetch_done_o <= 1'b1;
          end
        end
        default: begin
          state_q <= axi_rd_pkg::IDLE;
        end
      endcase
    end
  end

  // address captured at request time, held through the AR handshake
  always_ff @(posedge clk) begin
    if (state_q == axi_rd_pkg::IDLE && fetch_req_i) begin
      ar_addr_o <= fetch_addr_i;
    end
  end

  // beat captured on the R transfer, valid alongside fetch_done_o
  always_ff @(posedge clk) begin
    if (r_hs) begin
      fetch_data_o <= r_data_i;
      fetch_resp_o <= r_resp_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/pc_gen.sv
`timescale 1ns/10ps
`default_nettype none
`include "fetch_consts.svh"

module pc_gen (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          redirect_i,
  input  wire rv_core_pkg::pc_t        redirect_pc_i,
  input  wire                          stall_i,
  input  wire                          fetch_done_i,
  output logic                         fetch_req_o,
  output rv_core_pkg::pc_t             fetch_addr_o,
  output logic                         deliver_o
);

  rv_core_pkg::fetch_state_e state_q;
  rv_core_pkg::fetch_state_e state_d;
  rv_core_pkg::pc_t          pc_q;
  rv_core_pkg::pc_t          pc_d;
  // redirect target parked while a flushed fetch drains
  rv_core_pkg::pc_t          target_q;
  rv_core_pkg::pc_t          target_d;

  // pc_q only moves outside WAIT/FLUSH, so the address is stable until done
  assign fetch_addr_o = pc_q;

  always_comb begin
    state_d     = state_q;
    pc_d        = pc_q;
    target_d    = target_q;
    fetch_req_o = 1'b0;
    deliver_o   = 1'b0;
    case (state_q)
      rv_core_pkg::IDLE: begin
        if (redirect_i) begin
          pc_d = redirect_pc_i;
        end
        if (!stall_i) begin
          state_d = rv_core_pkg::REQ;
        end
      end
      rv_core_pkg::REQ: begin
        // redirect wins, request goes out next cycle with the new pc
        if (redirect_i) begin
          pc_d = redirect_pc_i;
        end else if (stall_i) begin
          state_d = rv_core_pkg::IDLE;
        end else begin
          fetch_req_o = 1'b1;
          state_d     = rv_core_pkg::WAIT;
        end
      end
      rv_core_pkg::WAIT: begin
        if (fetch_done_i) begin
          // redirect on the done cycle kills this instruction
          if (redirect_i) begin
            pc_d = redirect_pc_i;
          end else begin
            deliver_o = 1'b1;
            pc_d      = pc_q + 64'd4;
          end
          state_d = stall_i ? rv_core_pkg::IDLE : rv_core_pkg::REQ;
        end else if (redirect_i) begin
          target_d = redirect_pc_i;
          state_d  = rv_core_pkg::FLUSH;
        end
      end
      rv_core_pkg::FLUSH: begin
        // later redirects replace the parked target
        if (redirect_i) begin
          target_d = redirect_pc_i;
        end
        if (fetch_done_i) begin
          pc_d    = redirect_i ? redirect_pc_i : target_q;
          state_d = rv_core_pkg::REQ;
        end
      end
      default: begin
        state_d = rv_core_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= rv_core_pkg::IDLE;
      pc_q    <= `RESET_PC;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

  always_ff @(posedge clk) begin
    target_q <= target_d;
  end

endmodule

`default_nettype wire

// File: hw/axi_rd_pkg.sv
`default_nettype none

package axi_rd_pkg;

  typedef logic [63:0] axi_addr_t;
  typedef logic [63:0] axi_data_t;
  typedef logic [1:0]  axi_resp_t;

  // only the two codes this fabric produces
  localparam axi_resp_t OKAY   = 2'b00;
  localparam axi_resp_t DECERR = 2'b11;

  // read master sequencing, one beat per transaction
  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA
  } rd_state_e;

endpackage

`default_nettype wire

// File: hw/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  // fetch address, full xlen
  typedef logic [63:0] pc_t;

  // one uncompressed instruction
  typedef logic [31:0] inst_t;

  // pc unit states
  // IDLE  no fetch, waiting for stall to drop
  // REQ   fetch request offered to the read master
  // WAIT  fetch in flight
  // FLUSH fetch in flight whose data is thrown away
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT,
    FLUSH
  } fetch_state_e;

endpackage

`default_nettype wire

// File: hw/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// first fetch address out of reset
`define RESET_PC 64'h0000_0000_8000_0000

// instruction memory size in 64-bit words
`define IMEM_DEPTH 64

// cycles from AR transfer to r_valid
// must stay at 1 or more
`define IMEM_LATENCY 2

// addi x0, x0, 0
`define INST_NOP 32'h0000_0013

`endif
